/* Makefile */
VERILATOR  ?= verilator
TOP        := mpu_periph_tb
FILELIST   := build.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/irq_pkg.sv
rtl/bus_lane_steer.sv
rtl/bus_cycle_ctrl.sv
rtl/interval_timer.sv
rtl/irq_ctrl.sv
rtl/mpu_periph_top.sv
tests/mpu_periph_assert.sv
tests/mpu_periph_tb.sv

/* rtl/bus_cycle_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mpu_consts.svh"

module bus_cycle_ctrl import bus_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	input  wire logic                   cyc_i,
	input  wire logic                   stb_i,
	input  wire logic                   we_i,
	input  wire lane_t                  lane_i,
	input  wire logic [`MPU_ADDR_W-1:0] adr32_i,
	input  wire logic [`MPU_WORD_W-1:0] wdat_i,
	input  wire logic [`MPU_WORD_W-1:0] pit_rdat_i,
	input  wire logic [`MPU_WORD_W-1:0] pic_rdat_i,
	output logic                        pit_wr_o,
	output logic                        pit_rd_o,
	output logic                        pic_wr_o,
	output logic                        pic_rd_o,
	output logic [`MPU_OFF_W-1:0]       reg_off_o,
	output logic [`MPU_WORD_W-1:0]      reg_wdat_o,
	output logic                        ack_o,
	output logic                        err_o,
	output logic [`MPU_DATA_W-1:0]      dat_o
);

	localparam logic [`MPU_ADDR_W-1:0] pit_base = `MPU_PIT_BASE;
	localparam logic [`MPU_ADDR_W-1:0] pic_base = `MPU_PIC_BASE;

	bus_state_t                 state_q;
	periph_sel_t                psel_d;
	periph_sel_t                psel_q;     // target latched at request
	logic                       we_q;
	logic [`MPU_OFF_W-1:0]      off_q;
	logic [`MPU_WORD_W-1:0]     wdat_q;
	logic [`MPU_WORD_W-1:0]     rdat_mux;
	logic                       req;

	assign req = cyc_i & stb_i;

	// ========================================
	// decode
	// ========================================
	always_comb begin
		if (adr32_i[31:8] == pit_base[31:8])
			psel_d = psel_pit;
		else if (adr32_i[31:8] == pic_base[31:8])
			psel_d = psel_pic;
		else
			psel_d = psel_none;   // unmapped, answered with err
	end

	// request capture, payload only
	always_ff @(posedge clk_i) begin
		if (state_q == bs_idle && req) begin
			psel_q <= psel_d;
			we_q   <= we_i;
			off_q  <= {adr32_i[5:4], lane_i, 2'b00};   // lane gives a[3:2]
			wdat_q <= wdat_i;
		end
	end

	// sequencing
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= bs_idle;
			ack_o   <= 1'b0;
			err_o   <= 1'b0;
		end else begin
			ack_o <= 1'b0;   // both are single cycle
			err_o <= 1'b0;
			case (state_q)
				bs_idle:    if (req) state_q <= bs_access;
				bs_access:  state_q <= bs_respond;
				bs_respond: begin
					ack_o   <= (psel_q != psel_none);
					err_o   <= (psel_q == psel_none);
					state_q <= bs_hold;
				end
				default:    if (!stb_i) state_q <= bs_idle;   // bs_hold
			endcase
		end
	end

	// one cycle strobes while in access
	assign pit_wr_o = (state_q == bs_access) && (psel_q == psel_pit) && we_q;
	assign pit_rd_o = (state_q == bs_access) && (psel_q == psel_pit) && !we_q;
	assign pic_wr_o = (state_q == bs_access) && (psel_q == psel_pic) && we_q;
	assign pic_rd_o = (state_q == bs_access) && (psel_q == psel_pic) && !we_q;

	assign reg_off_o  = off_q;
	assign reg_wdat_o = wdat_q;

	// ========================================
	// read return
	// ========================================
	always_comb begin
		case (psel_q)
			psel_pit: rdat_mux = pit_rdat_i;
			psel_pic: rdat_mux = pic_rdat_i;
			default:  rdat_mux = '0;
		endcase
	end

	// word copied onto every lane, master picks its own
	always_ff @(posedge clk_i) begin
		if (state_q == bs_respond && !we_q)
			dat_o <= {4{rdat_mux}};
	end

endmodule

`default_nettype wire

/* rtl/bus_lane_steer.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mpu_consts.svh"

module bus_lane_steer import bus_pkg::*; (
	input  wire logic [`MPU_SEL_W-1:0]  sel_i,
	input  wire logic [`MPU_ADDR_W-1:0] adr_i,
	input  wire logic [`MPU_DATA_W-1:0] dat_i,
	output lane_t                       lane_o,
	output logic [`MPU_ADDR_W-1:0]      adr32_o,
	output logic [`MPU_WORD_W-1:0]      wdat_o
);

	logic a3;   // rebuilt address bit 3
	logic a2;   // rebuilt address bit 2

	// ========================================
	// address rebuild
	// ========================================
	// the wide bus drops a[3:2], recover them from the active select group
	assign a3 = |sel_i[15:8];
	assign a2 = (|sel_i[7:4]) | (|sel_i[15:12]);

	assign adr32_o = {adr_i[`MPU_ADDR_W-1:4], a3, a2, 2'b00};   // word aligned

	// lane pick, only the four clean masks are honoured
	always_comb begin
		case (sel_i)
			16'h00F0: lane_o = 2'd1;
			16'h0F00: lane_o = 2'd2;
			16'hF000: lane_o = 2'd3;
			default:  lane_o = 2'd0;   // 000F and malformed masks
		endcase
	end

	// 32 bit write word out of the selected lane
	assign wdat_o = dat_i[{lane_o, 5'b00000} +: `MPU_WORD_W];

endmodule

`default_nettype wire

/* rtl/bus_pkg.sv */
`default_nettype none

`include "mpu_consts.svh"

package bus_pkg;

	// which 32 bit lane of the wide bus is addressed
	typedef logic [$clog2(`MPU_DATA_W / `MPU_WORD_W)-1:0] lane_t;

	// decoded target of an access
	typedef enum logic [1:0] {
		psel_none,      // nothing answers, bus error
		psel_pit,
		psel_pic
	} periph_sel_t;

	// ========================================
	// bus cycle sequencing
	// ========================================
	typedef enum logic [1:0] {
		bs_idle,        // waiting for cyc & stb
		bs_access,      // strobe to the peripheral
		bs_respond,     // capture read word, raise ack/err
		bs_hold         // wait for master to drop stb
	} bus_state_t;

endpackage

`default_nettype wire

/* rtl/interval_timer.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mpu_consts.svh"

module interval_timer import irq_pkg::*; (
	input  wire logic                     clk_i,
	input  wire logic                     reset_i,
	input  wire logic                     wr_i,
	input  wire logic                     rd_i,
	input  wire logic [`MPU_OFF_W-1:0]    off_i,
	input  wire logic [`MPU_WORD_W-1:0]   wdat_i,
	output logic [`MPU_WORD_W-1:0]        rdat_o,
	output logic [`MPU_PIT_CHANS-1:0]     out_o
);

	pit_reg_u               reload_q [`MPU_PIT_CHANS];
	pit_reg_u               count_q  [`MPU_PIT_CHANS];
	pit_reg_u               ctrl_q   [`MPU_PIT_CHANS];
	pit_reg_u               wr_view;    // incoming write word
	logic [1:0]             ch_sel;
	logic [3:0]             reg_sel;
	logic                   ch_ok;

	assign ch_sel  = off_i[5:4];   // 16 byte stride per channel
	assign reg_sel = off_i[3:0];
	assign ch_ok   = (ch_sel < 2'(`MPU_PIT_CHANS));
	assign wr_view = wdat_i;

	// reload words, plain storage
	always_ff @(posedge clk_i) begin
		if (wr_i && ch_ok && reg_sel == `MPU_PIT_RELOAD)
			reload_q[ch_sel].count <= wr_view.count;
	end

	// ========================================
	// counting
	// ========================================
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < `MPU_PIT_CHANS; i++) begin
				ctrl_q[i]  <= '0;
				count_q[i] <= '0;
			end
			out_o <= '0;
		end else begin
			for (int i = 0; i < `MPU_PIT_CHANS; i++) begin
				out_o[i] <= 1'b0;   // pulse lasts one clock
				if (wr_i && ch_sel == 2'(i) && reg_sel == `MPU_PIT_CTRL) begin
					ctrl_q[i].ctrl.enable      <= wr_view.ctrl.enable;
					ctrl_q[i].ctrl.auto_reload <= wr_view.ctrl.auto_reload;
					ctrl_q[i].ctrl.rsvd        <= '0;
					if (wr_view.ctrl.enable)
						count_q[i].count <= reload_q[i].count;   // arm from reload
				end else if (wr_i && ch_sel == 2'(i) && reg_sel == `MPU_PIT_COUNT) begin
					count_q[i].count <= wr_view.count;   // direct preset
				end else if (ctrl_q[i].ctrl.enable) begin
					if (count_q[i].count == '0) begin
						out_o[i] <= 1'b1;
						if (ctrl_q[i].ctrl.auto_reload)
							count_q[i].count <= reload_q[i].count;
						else
							ctrl_q[i].ctrl.enable <= 1'b0;   // one shot done, stays at 0
					end else begin
						count_q[i].count <= count_q[i].count - 1'b1;
					end
				end
			end
		end
	end

	// ========================================
	// read port
	// ========================================
	// registered, valid the cycle after rd_i
	always_ff @(posedge clk_i) begin
		if (rd_i) begin
			if (!ch_ok)
				rdat_o <= '0;
			else begin
				case (reg_sel)
					`MPU_PIT_RELOAD: rdat_o <= reload_q[ch_sel].count;
					`MPU_PIT_COUNT:  rdat_o <= count_q[ch_sel].count;   // live count
					`MPU_PIT_CTRL:   rdat_o <= ctrl_q[ch_sel].count;     // raw flags
					default:         rdat_o <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/irq_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mpu_consts.svh"

module irq_ctrl import irq_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	input  wire logic                   wr_i,
	input  wire logic                   rd_i,
	input  wire logic [`MPU_OFF_W-1:0]  off_i,
	input  wire logic [`MPU_WORD_W-1:0] wdat_i,
	input  wire irq_src_t               src_i,
	output logic [`MPU_WORD_W-1:0]      rdat_o,
	output irq_level_t                  irq_o,
	output irq_cause_t                  cause_o
);

	irq_src_t       src_q;      // previous source levels
	irq_src_t       rise;
	irq_src_t       pending_q;
	irq_src_t       enable_q;
	irq_src_t       active;
	logic [15:0]    levels_q;   // four groups of eight sources, 4 bits each
	irq_cause_t     cause_d;
	irq_level_t     level_d;

	// ========================================
	// edge detect
	// ========================================
	always_ff @(posedge clk_i) begin
		src_q <= src_i;   // tracks during reset so no edge fires on release
	end

	assign rise = src_i & ~src_q & ~irq_src_t'(1);   // source 0 does not exist

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pending_q <= '0;
			enable_q  <= '0;
			levels_q  <= '0;
		end else begin
			// new edges win over a clear in the same cycle
			if (wr_i && off_i == `MPU_PIC_PENDING)
				pending_q <= (pending_q & ~wdat_i) | rise;
			else
				pending_q <= pending_q | rise;
			if (wr_i && off_i == `MPU_PIC_ENABLE)
				enable_q <= wdat_i & ~irq_src_t'(1);
			if (wr_i && off_i == `MPU_PIC_LEVELS)
				levels_q <= wdat_i[15:0];
		end
	end

	assign active = pending_q & enable_q;

	// ========================================
	// priority
	// ========================================
	// highest numbered active source wins
	always_comb begin
		cause_d = '0;
		for (int i = 1; i < `MPU_IRQ_SRCS; i++) begin
			if (active[i])
				cause_d = irq_cause_t'(i);
		end
	end

	// level from the winner's group
	assign level_d = (cause_d == '0) ? '0 : levels_q[{cause_d[4:3], 2'b00} +: 4];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			irq_o   <= '0;
			cause_o <= '0;
		end else begin
			irq_o   <= level_d;
			cause_o <= cause_d;
		end
	end

	// register reads, one cycle behind rd_i
	always_ff @(posedge clk_i) begin
		if (rd_i) begin
			case (off_i)
				`MPU_PIC_ENABLE:  rdat_o <= enable_q;
				`MPU_PIC_PENDING: rdat_o <= pending_q;
				`MPU_PIC_CAUSE:   rdat_o <= {24'h0, cause_o};
				`MPU_PIC_LEVELS:  rdat_o <= {16'h0, levels_q};
				default:          rdat_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/irq_pkg.sv */
`default_nettype none

`include "mpu_consts.svh"

package irq_pkg;

	// one bit per source, bit 0 unused
	typedef logic [`MPU_IRQ_SRCS-1:0] irq_src_t;

	typedef logic [7:0] irq_cause_t;   // source number, 0 = none
	typedef logic [3:0] irq_level_t;   // priority level to the cpu

	// ========================================
	// timer register word
	// ========================================
	// same 32 bits seen as a plain count or as control flags
	typedef union packed {
		logic [`MPU_WORD_W-1:0] count;
		struct packed {
			logic [`MPU_WORD_W-3:0] rsvd;   // reads back zero
			logic auto_reload;               // restart from reload at zero
			logic enable;                    // channel counting
		} ctrl;
	} pit_reg_u;

endpackage

`default_nettype wire

/* rtl/mpu_consts.svh */
`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// ========================================
// bus geometry
// ========================================
`define MPU_DATA_W      128     // master data bus
`define MPU_ADDR_W      32
`define MPU_SEL_W       16      // one select per byte
`define MPU_WORD_W      32      // peripheral word
`define MPU_OFF_W       6       // register offset seen by peripherals

// peripheral bases, only [31:8] is decoded
`define MPU_PIT_BASE    32'hFFDC_1100
`define MPU_PIC_BASE    32'hFFDC_0F00

// ========================================
// timer map
// ========================================
`define MPU_PIT_CHANS   3
`define MPU_PIT_RELOAD  4'h0    // offsets within a 16 byte channel slot
`define MPU_PIT_COUNT   4'h4
`define MPU_PIT_CTRL    4'h8

// ========================================
// interrupt controller map
// ========================================
`define MPU_IRQ_SRCS    32      // bit 0 never fires
`define MPU_PIC_ENABLE  6'h00
`define MPU_PIC_PENDING 6'h04   // write one to clear
`define MPU_PIC_CAUSE   6'h08   // read only
`define MPU_PIC_LEVELS  6'h0C

`endif

/* rtl/mpu_periph_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mpu_consts.svh"

module mpu_periph_top import bus_pkg::*, irq_pkg::*; (
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	input  wire logic                   cyc_i,
	input  wire logic                   stb_i,
	input  wire logic                   we_i,
	input  wire logic [`MPU_SEL_W-1:0]  sel_i,
	input  wire logic [`MPU_ADDR_W-1:0] adr_i,
	input  wire logic [`MPU_DATA_W-1:0] dat_i,
	input  wire logic [`MPU_IRQ_SRCS-`MPU_PIT_CHANS-2:0] irq_src_i,   // sources 1..28
	output logic                        ack_o,
	output logic                        err_o,
	output logic [`MPU_DATA_W-1:0]      dat_o,
	output irq_level_t                  irq_o,
	output irq_cause_t                  cause_o,
	output logic                        pit_out2_o
);

	lane_t                      lane;
	logic [`MPU_ADDR_W-1:0]     adr32;
	logic [`MPU_WORD_W-1:0]     wdat32;
	logic                       pit_wr, pit_rd, pic_wr, pic_rd;
	logic [`MPU_OFF_W-1:0]      reg_off;
	logic [`MPU_WORD_W-1:0]     reg_wdat;
	logic [`MPU_WORD_W-1:0]     pit_rdat, pic_rdat;
	logic [`MPU_PIT_CHANS-1:0]  pit_out;
	irq_src_t                   src_vec;

	// ========================================
	// bus side
	// ========================================
	bus_lane_steer u_steer (
		.sel_i(sel_i), .adr_i(adr_i), .dat_i(dat_i),
		.lane_o(lane), .adr32_o(adr32), .wdat_o(wdat32)
	);

	bus_cycle_ctrl u_cycle (
		.clk_i(clk_i), .reset_i(reset_i),
		.cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
		.lane_i(lane), .adr32_i(adr32), .wdat_i(wdat32),
		.pit_rdat_i(pit_rdat), .pic_rdat_i(pic_rdat),
		.pit_wr_o(pit_wr), .pit_rd_o(pit_rd), .pic_wr_o(pic_wr), .pic_rd_o(pic_rd),
		.reg_off_o(reg_off), .reg_wdat_o(reg_wdat),
		.ack_o(ack_o), .err_o(err_o), .dat_o(dat_o)
	);

	// ========================================
	// peripherals
	// ========================================
	interval_timer u_pit (
		.clk_i(clk_i), .reset_i(reset_i),
		.wr_i(pit_wr), .rd_i(pit_rd), .off_i(reg_off), .wdat_i(reg_wdat),
		.rdat_o(pit_rdat), .out_o(pit_out)
	);

	// timer ch0 -> 31, ch1 -> 30, ch2 -> 29, externals below, bit 0 idle
	assign src_vec = {pit_out[0], pit_out[1], pit_out[2], irq_src_i, 1'b0};

	irq_ctrl u_pic (
		.clk_i(clk_i), .reset_i(reset_i),
		.wr_i(pic_wr), .rd_i(pic_rd), .off_i(reg_off), .wdat_i(reg_wdat),
		.src_i(src_vec),
		.rdat_o(pic_rdat), .irq_o(irq_o), .cause_o(cause_o)
	);

	assign pit_out2_o = pit_out[2];

endmodule

`default_nettype wire

/* tests/mpu_periph_assert.sv */
`default_nettype none
`timescale 1ns/100ps

module mpu_periph_assert import irq_pkg::*; (
	input wire logic       clk_i,
	input wire logic       reset_i,
	input wire logic       ack_i,
	input wire logic       err_i,
	input wire irq_level_t irq_i,
	input wire irq_cause_t cause_i
);

	int unsigned fail_cnt = 0;   // polled by the testbench at the end

	// ========================================
	// bus response
	// ========================================
	ack_err_excl: assert property (@(posedge clk_i) disable iff (reset_i) !(ack_i && err_i))
		else begin
			$error("ack and err high in the same cycle");
			fail_cnt++;
		end

	ack_single: assert property (@(posedge clk_i) disable iff (reset_i) ack_i |=> !ack_i)
		else begin
			$error("ack wider than one cycle");
			fail_cnt++;
		end

	err_single: assert property (@(posedge clk_i) disable iff (reset_i) err_i |=> !err_i)
		else begin
			$error("err wider than one cycle");
			fail_cnt++;
		end

	// no reset gating here, it checks reset itself
	ack_after_reset: assert property (@(posedge clk_i) reset_i |=> !ack_i)
		else begin
			$error("ack high right after reset");
			fail_cnt++;
		end

	// ========================================
	// interrupt outputs
	// ========================================
	level_has_cause: assert property (@(posedge clk_i) disable iff (reset_i)
		(irq_i != '0) |-> (cause_i != '0))
		else begin
			$error("nonzero level with no cause");
			fail_cnt++;
		end

endmodule

`default_nettype wire

/* tests/mpu_periph_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "mpu_consts.svh"

module mpu_periph_tb import irq_pkg::*;;

	localparam logic [31:0] pit_base = `MPU_PIT_BASE;
	localparam logic [31:0] pic_base = `MPU_PIC_BASE;
	localparam int n_access     = 24;              // upper bound on bus accesses
	localparam int timer_cyc    = 2 * 40 + 60;     // pulse wait plus quiet window
	localparam int watchdog_cyc = n_access * 10 + timer_cyc + 30;
	// per lane: a register that reads back, and which bits survive
	localparam logic [31:0] lane_addr [4] = '{`MPU_PIC_BASE, `MPU_PIT_BASE + 32'h14,
		`MPU_PIT_BASE + 32'h18, `MPU_PIC_BASE + 32'h0C};
	localparam logic [31:0] lane_mask [4] = '{32'hFFFF_FFFE, 32'hFFFF_FFFF,
		32'h0000_0002, 32'h0000_FFFF};

	logic clk_i, reset_i, cyc_i, stb_i, we_i;
	logic [15:0]  sel_i;
	logic [31:0]  adr_i;
	logic [127:0] dat_i;
	logic [27:0]  irq_src_i;
	logic         ack_o, err_o, pit_out2_o;
	logic [127:0] dat_o;
	irq_level_t   irq_o;
	irq_cause_t   cause_o;

	logic [31:0] lcg_state = 32'he3aa_5e77;
	irq_src_t    exp_pending = '0;   // model state
	irq_src_t    exp_enable = '0;
	logic [15:0] exp_levels = '0;
	int unsigned cyc_cnt = 0;
	int unsigned ack_cyc;
	int unsigned pulse_cyc;
	int          pulse_cnt = 0;

	mpu_periph_top DUT (
		.clk_i(clk_i), .reset_i(reset_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
		.sel_i(sel_i), .adr_i(adr_i), .dat_i(dat_i), .irq_src_i(irq_src_i),
		.ack_o(ack_o), .err_o(err_o), .dat_o(dat_o), .irq_o(irq_o), .cause_o(cause_o),
		.pit_out2_o(pit_out2_o)
	);

	bind mpu_periph_top mpu_periph_assert u_assert (.clk_i(clk_i), .reset_i(reset_i),
		.ack_i(ack_o), .err_i(err_o), .irq_i(irq_o), .cause_i(cause_o));

	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

	// timer channel 2 pulse log, read back on rising edges
	always @(negedge clk_i) begin
		if (!reset_i && pit_out2_o) begin
			pulse_cnt++;
			pulse_cyc = cyc_cnt;
		end
	end

	// protocol checker tally
	always @(negedge clk_i) begin
		if (DUT.u_assert.fail_cnt != 0)
			abort_run("a bus or interrupt protocol assertion failed");
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ========================================
	// reference model
	// ========================================
	function automatic void ref_irq(input irq_src_t pend, input irq_src_t en,
			input logic [15:0] lv, output irq_cause_t cause, output irq_level_t level);
		irq_src_t act;
		act = pend & en;
		cause = '0;
		level = '0;
		for (int s = 31; s >= 1; s--) begin   // top source first
			if (act[s] && cause == '0) begin
				cause = irq_cause_t'(s);
				level = lv[(s / 8) * 4 +: 4];   // eight sources per group
			end
		end
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
	endtask

	task automatic check_cause(input string name, input irq_cause_t got, input irq_cause_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %0d exp %0d", $time, name, got, exp));
	endtask

	task automatic check_level(input string name, input irq_level_t got, input irq_level_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %0d exp %0d", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %b exp %b", $time, name, got, exp));
	endtask

	task automatic check_irq_outputs();
		irq_cause_t c;
		irq_level_t l;
		ref_irq(exp_pending, exp_enable, exp_levels, c, l);
		check_cause("cause_o", cause_o, c);
		check_level("irq_o", irq_o, l);
	endtask

	// ========================================
	// bus master
	// ========================================
	task automatic bus_cycle(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
			input logic exp_err, output logic [127:0] rdata);
		logic [1:0]   ln;
		logic [127:0] word;
		int           lat;
		ln = addr[3:2];   // word slot becomes the lane
		word = {next_rand(), next_rand(), next_rand(), next_rand()};   // junk on idle lanes
		word[ln * 32 +: 32] = wdata;
		@(posedge clk_i);
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i  <= wr;
		sel_i <= 16'h000F << (ln * 4);
		adr_i <= {addr[31:4], 4'h0};   // wide bus drops a[3:0]
		dat_i <= word;
		lat = 0;
		@(negedge clk_i);
		while (!(ack_o || err_o)) begin
			if (lat > 8)
				abort_run("no ack or err within 8 cycles of a request");
			@(negedge clk_i);
			lat++;
		end
		rdata = dat_o;
		ack_cyc = cyc_cnt;
		if (lat != 3)   // drive edge, then sample edge plus two
			abort_run($sformatf("ERR %0t ack_o latency got %0d exp 2", $time, lat - 1));
		check_flag("err_o", err_o, exp_err);
		check_flag("ack_o", ack_o, !exp_err);
		@(posedge clk_i);
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
		logic [127:0] unused_rd;
		bus_cycle(1'b1, addr, wdata, 1'b0, unused_rd);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [127:0] rdata);
		bus_cycle(1'b0, addr, 32'h0, 1'b0, rdata);
	endtask

	initial begin
		repeat (watchdog_cyc) @(posedge clk_i);
		abort_run("watchdog expired before the tests finished");
	end

	// ========================================
	// test sequence
	// ========================================
	initial begin
		logic [127:0] rd;
		logic [31:0]  w;
		logic [27:0]  src_new;
		int           r;
		int           waited;
		clk_i = 1'b0;
		reset_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		sel_i = '0;
		adr_i = '0;
		dat_i = '0;
		irq_src_i = '0;
		repeat (3) @(posedge clk_i);
		reset_i <= 1'b0;

		for (int k = 0; k < 4; k++) begin   // one write per lane, lane 0 is the enable mask
			w = next_rand() & lane_mask[k];
			bus_write(lane_addr[k], w);
			bus_read(lane_addr[k], rd);
			check_data("dat_o", rd, {4{w}});
			if (k == 0) exp_enable = w;
			if (k == 3) exp_levels = w[15:0];
		end
		bus_cycle(1'b0, 32'h1234_5600, 32'h0, 1'b1, rd);   // unmapped

		w = next_rand();
		exp_levels = w[15:0];
		bus_write(pic_base + `MPU_PIC_LEVELS, w);
		exp_enable = next_rand() & 32'hFFFF_FFFE;
		bus_write(pic_base + `MPU_PIC_ENABLE, exp_enable);
		for (int k = 0; k < 3; k++) begin
			w = next_rand();
			src_new = w[27:0];
			exp_pending = exp_pending | {3'b000, src_new & ~irq_src_i, 1'b0};   // rising only
			@(posedge clk_i);
			irq_src_i <= src_new;
			repeat (2) @(posedge clk_i);
			@(negedge clk_i);
			check_irq_outputs();
		end

		for (int k = 0; k < 3; k++) begin   // peel off the top sources
			irq_cause_t c;
			irq_level_t l;
			ref_irq(exp_pending, exp_enable, exp_levels, c, l);
			if (c != '0) begin
				bus_write(pic_base + `MPU_PIC_PENDING, 32'h1 << c);
				exp_pending[c] = 1'b0;
				@(negedge clk_i);
				check_irq_outputs();
			end
		end
		bus_write(pic_base + `MPU_PIC_PENDING, 32'hFFFF_FFFF);
		exp_pending = '0;
		@(negedge clk_i);
		check_irq_outputs();

		// one shot on channel 2, routed to source 29
		exp_enable = 32'h2000_0000;
		bus_write(pic_base + `MPU_PIC_ENABLE, exp_enable);
		r = 2 + int'(next_rand() % 39);
		bus_write(pit_base + 32'h20 + `MPU_PIT_RELOAD, r);
		bus_write(pit_base + 32'h20 + `MPU_PIT_CTRL, 32'h1);   // enable, no auto reload
		waited = 0;
		while (pulse_cnt == 0) begin
			@(posedge clk_i);
			waited++;
			if (waited > 60)
				abort_run("timer channel 2 never pulsed");
		end
		if (pulse_cyc - ack_cyc != r)   // ack trails the enable by one clock
			abort_run($sformatf("ERR %0t pit_out2_o delay got %0d exp %0d",
				$time, pulse_cyc - ack_cyc + 1, r + 1));
		exp_pending[29] = 1'b1;
		@(posedge clk_i);
		@(negedge clk_i);
		check_cause("cause_o", cause_o, 8'd29);
		check_irq_outputs();
		repeat (2 * r + 10) @(posedge clk_i);
		if (pulse_cnt != 1)
			abort_run("timer channel 2 pulsed again after its one shot");
		bus_read(pit_base + 32'h20 + `MPU_PIT_COUNT, rd);
		check_data("dat_o", rd, '0);

		if (DUT.u_assert.fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run("an assertion failed during the run");
		end
	end

endmodule

`default_nettype wire
